//--- source/wolf_pkg.sv
`default_nettype none

package wolf_pkg;

   // ********************
   // Bus widths and types
   localparam int unsigned BUS_DATA_W = 32;
   localparam int unsigned BUS_ADDR_W = 16;
   localparam int unsigned BUS_SEL_W  = 4;

   typedef logic [BUS_DATA_W-1:0] bus_word_t;
   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [BUS_SEL_W-1:0]  bus_sel_t;

   // ********************
   // Address map, region is the top nibble
   localparam int unsigned REGION_LSB  = 12;
   localparam logic [3:0]  REGION_RAM  = 4'd0;
   localparam logic [3:0]  REGION_SYS  = 4'd1;
   localparam logic [3:0]  REGION_GPIO = 4'd2;
   localparam logic [3:0]  REGION_RGB  = 4'd3;

   localparam int unsigned RAM_WORDS = 256;

   // ********************
   // Register offsets inside a target
   localparam int unsigned REG_OFS_W = 4;

   localparam logic [REG_OFS_W-1:0] SYS_MTIME    = 4'h0;
   localparam logic [REG_OFS_W-1:0] SYS_MTIMECMP = 4'h4;
   localparam logic [REG_OFS_W-1:0] SYS_CTRL     = 4'h8;

   localparam logic [REG_OFS_W-1:0] GPIO_IN  = 4'h0;
   localparam logic [REG_OFS_W-1:0] GPIO_OUT = 4'h4;
   localparam logic [REG_OFS_W-1:0] GPIO_OE  = 4'h8;

   localparam logic [REG_OFS_W-1:0] RGB_LED0 = 4'h0;
   localparam logic [REG_OFS_W-1:0] RGB_LED1 = 4'h4;
   localparam logic [REG_OFS_W-1:0] RGB_DUTY = 4'h8;

   // Red, green, blue
   typedef logic [2:0] rgb_color_t;
   typedef logic [7:0] pwm_t;

endpackage

`default_nettype wire

//--- source/wb_if.sv
`default_nettype none

interface wb_if;

   // Request
   logic                cyc;
   logic                stb;
   logic                we;
   wolf_pkg::bus_addr_t adr;
   wolf_pkg::bus_word_t dat_w;
   wolf_pkg::bus_sel_t  sel;

   // Reply
   wolf_pkg::bus_word_t dat_r;
   logic                ack;
   logic                err;

   modport initiator (
      output cyc, stb, we, adr, dat_w, sel,
      input  dat_r, ack, err
   );

   modport decoder (
      input  cyc, stb, we, adr, dat_w, sel,
      output dat_r, ack, err
   );

   // Targets only ack, errors come from the decoder
   modport target (
      input  cyc, stb, we, adr, dat_w, sel,
      output dat_r, ack
   );

endinterface

`default_nettype wire

//--- source/wb_arbiter.sv
`default_nettype none

module wb_arbiter
   import wolf_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst,
   wb_if.decoder   cpu,
   wb_if.decoder   dbg,
   wb_if.initiator bus
);

   logic busy;
   logic sel_dbg;
   logic req_cpu;
   logic req_dbg;
   logic pick_dbg;

   assign req_cpu = cpu.cyc & cpu.stb;
   assign req_dbg = dbg.cyc & dbg.stb;

   // Round robin, a tie goes to the master not granted last
   assign pick_dbg = req_dbg & (~req_cpu | ~sel_dbg);

   // ********************
   // Grant state
   always_ff @(posedge clk) begin
      if (i_rst) begin
         busy    <= 1'b0;
         sel_dbg <= 1'b0;
      end else if (!busy) begin
         if (req_cpu | req_dbg) begin
            busy    <= 1'b1;
            sel_dbg <= pick_dbg;
         end
      end else if (bus.ack | bus.err) begin
         // Released on the closing edge of the cycle
         busy <= 1'b0;
      end
   end

   // ********************
   // Request forwarding
   assign bus.cyc   = busy & (sel_dbg ? dbg.cyc : cpu.cyc);
   assign bus.stb   = busy & (sel_dbg ? dbg.stb : cpu.stb);
   assign bus.we    = sel_dbg ? dbg.we : cpu.we;
   assign bus.adr   = sel_dbg ? dbg.adr : cpu.adr;
   assign bus.dat_w = sel_dbg ? dbg.dat_w : cpu.dat_w;
   assign bus.sel   = sel_dbg ? dbg.sel : cpu.sel;

   // Replies go only to the owner
   assign cpu.dat_r = (busy & ~sel_dbg) ? bus.dat_r : '0;
   assign cpu.ack   = busy & ~sel_dbg & bus.ack;
   assign cpu.err   = busy & ~sel_dbg & bus.err;

   assign dbg.dat_r = (busy & sel_dbg) ? bus.dat_r : '0;
   assign dbg.ack   = busy & sel_dbg & bus.ack;
   assign dbg.err   = busy & sel_dbg & bus.err;

endmodule

`default_nettype wire

//--- source/wb_decoder.sv
`default_nettype none

module wb_decoder
   import wolf_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst,
   wb_if.decoder   bus,
   wb_if.initiator ram,
   wb_if.initiator sys,
   wb_if.initiator gpio,
   wb_if.initiator rgb
);

   logic [BUS_ADDR_W-REGION_LSB-1:0] region;
   logic                             req;
   logic                             hole;
   logic                             err_q;

   assign region = bus.adr[BUS_ADDR_W-1:REGION_LSB];
   assign req    = bus.cyc & bus.stb;
   assign hole   = !(region inside {REGION_RAM, REGION_SYS, REGION_GPIO, REGION_RGB});

   // ********************
   // Request fan-out, strobe only to the selected target
   assign ram.cyc   = bus.cyc;
   assign ram.stb   = req & (region == REGION_RAM);
   assign ram.we    = bus.we;
   assign ram.adr   = bus.adr;
   assign ram.dat_w = bus.dat_w;
   assign ram.sel   = bus.sel;

   assign sys.cyc   = bus.cyc;
   assign sys.stb   = req & (region == REGION_SYS);
   assign sys.we    = bus.we;
   assign sys.adr   = bus.adr;
   assign sys.dat_w = bus.dat_w;
   assign sys.sel   = bus.sel;

   assign gpio.cyc   = bus.cyc;
   assign gpio.stb   = req & (region == REGION_GPIO);
   assign gpio.we    = bus.we;
   assign gpio.adr   = bus.adr;
   assign gpio.dat_w = bus.dat_w;
   assign gpio.sel   = bus.sel;

   assign rgb.cyc   = bus.cyc;
   assign rgb.stb   = req & (region == REGION_RGB);
   assign rgb.we    = bus.we;
   assign rgb.adr   = bus.adr;
   assign rgb.dat_w = bus.dat_w;
   assign rgb.sel   = bus.sel;

   // ********************
   // Reply mux
   always_comb begin
      bus.dat_r = '0;
      bus.ack   = 1'b0;
      case (region)
         REGION_RAM: begin
            bus.dat_r = ram.dat_r;
            bus.ack   = ram.ack;
         end
         REGION_SYS: begin
            bus.dat_r = sys.dat_r;
            bus.ack   = sys.ack;
         end
         REGION_GPIO: begin
            bus.dat_r = gpio.dat_r;
            bus.ack   = gpio.ack;
         end
         REGION_RGB: begin
            bus.dat_r = rgb.dat_r;
            bus.ack   = rgb.ack;
         end
         default: begin
            bus.dat_r = '0;
            bus.ack   = 1'b0;
         end
      endcase
   end

   // Holes answer with a one-cycle error
   always_ff @(posedge clk) begin
      if (i_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & hole & ~err_q;
      end
   end

   assign bus.err = err_q;

endmodule

`default_nettype wire

//--- source/boot_ram.sv
`default_nettype none

module boot_ram
   import wolf_pkg::*;
(
   input  logic clk,
   input  logic i_rst,
   wb_if.target bus
);

   localparam int unsigned IDX_W = $clog2(RAM_WORDS);

   bus_word_t        mem [RAM_WORDS];
   logic [IDX_W-1:0] idx;
   logic             access;

   // Word index, aliases inside the region
   assign idx    = bus.adr[IDX_W+1:2];
   assign access = bus.cyc & bus.stb & ~bus.ack;

   // Byte-lane writes
   always_ff @(posedge clk) begin
      if (access && bus.we) begin
         for (int i = 0; i < BUS_SEL_W; i++) begin
            if (bus.sel[i]) begin
               mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      bus.dat_r <= mem[idx];
   end

   // Single ack per request
   always_ff @(posedge clk) begin
      if (i_rst) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= access;
      end
   end

endmodule

`default_nettype wire

//--- source/sys_timer.sv
`default_nettype none

module sys_timer
   import wolf_pkg::*;
(
   input  logic clk,
   input  logic i_rst,
   wb_if.target bus,
   output logic o_timer_irq
);

   bus_word_t            mtime;
   bus_word_t            mtimecmp;
   logic                 irq_en;
   logic                 wr_en;
   logic [REG_OFS_W-1:0] ofs;
   bus_word_t            rdata;

   assign ofs   = bus.adr[REG_OFS_W-1:0];
   assign wr_en = bus.cyc & bus.stb & bus.we & ~bus.ack;

   // ********************
   // Counter and registers
   always_ff @(posedge clk) begin
      if (i_rst) begin
         mtime    <= '0;
         mtimecmp <= '1;
         irq_en   <= 1'b0;
      end else begin
         mtime <= mtime + 1'b1;
         if (wr_en) begin
            case (ofs)
               SYS_MTIME:    mtime    <= bus.dat_w;
               SYS_MTIMECMP: mtimecmp <= bus.dat_w;
               SYS_CTRL:     irq_en   <= bus.dat_w[0];
               default: ;
            endcase
         end
      end
   end

   // Level interrupt, registered
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_timer_irq <= 1'b0;
      end else begin
         o_timer_irq <= irq_en & (mtime >= mtimecmp);
      end
   end

   // ********************
   // Bus reply
   always_comb begin
      case (ofs)
         SYS_MTIME:    rdata = mtime;
         SYS_MTIMECMP: rdata = mtimecmp;
         SYS_CTRL:     rdata = bus_word_t'(irq_en);
         default:      rdata = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      bus.dat_r <= rdata;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.cyc & bus.stb & ~bus.ack;
      end
   end

endmodule

`default_nettype wire

//--- source/gpio_port.sv
`default_nettype none

module gpio_port
   import wolf_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst,
   wb_if.target      bus,
   input  bus_word_t i_gpio,
   output bus_word_t o_gpio,
   output bus_word_t o_gpio_oe
);

   bus_word_t            gpio_meta;
   bus_word_t            gpio_sync;
   bus_word_t            gpio_out;
   bus_word_t            gpio_oe;
   logic                 wr_en;
   logic [REG_OFS_W-1:0] ofs;
   bus_word_t            rdata;

   assign ofs   = bus.adr[REG_OFS_W-1:0];
   assign wr_en = bus.cyc & bus.stb & bus.we & ~bus.ack;

   // Two-flop input synchronizer
   always_ff @(posedge clk) begin
      gpio_meta <= i_gpio;
      gpio_sync <= gpio_meta;
   end

   // ********************
   // Output and enable registers
   always_ff @(posedge clk) begin
      if (i_rst) begin
         gpio_out <= '0;
         gpio_oe  <= '0;
      end else if (wr_en) begin
         case (ofs)
            GPIO_OUT: gpio_out <= bus.dat_w;
            GPIO_OE:  gpio_oe  <= bus.dat_w;
            default: ;
         endcase
      end
   end

   assign o_gpio    = gpio_out;
   assign o_gpio_oe = gpio_oe;

   always_comb begin
      case (ofs)
         GPIO_IN:  rdata = gpio_sync;
         GPIO_OUT: rdata = gpio_out;
         GPIO_OE:  rdata = gpio_oe;
         default:  rdata = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      bus.dat_r <= rdata;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.cyc & bus.stb & ~bus.ack;
      end
   end

endmodule

`default_nettype wire

//--- source/rgb_led.sv
`default_nettype none

module rgb_led
   import wolf_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst,
   wb_if.target       bus,
   output rgb_color_t o_rgb0,
   output rgb_color_t o_rgb1
);

   rgb_color_t           led0;
   rgb_color_t           led1;
   pwm_t                 duty;
   pwm_t                 pwm_cnt;
   logic                 wr_en;
   logic                 lit;
   logic [REG_OFS_W-1:0] ofs;
   bus_word_t            rdata;

   assign ofs   = bus.adr[REG_OFS_W-1:0];
   assign wr_en = bus.cyc & bus.stb & bus.we & ~bus.ack;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         led0    <= '0;
         led1    <= '0;
         duty    <= '0;
         pwm_cnt <= '0;
      end else begin
         // Free-running, one period is 256 cycles
         pwm_cnt <= pwm_cnt + 1'b1;
         if (wr_en) begin
            case (ofs)
               RGB_LED0: led0 <= bus.dat_w[2:0];
               RGB_LED1: led1 <= bus.dat_w[2:0];
               RGB_DUTY: duty <= bus.dat_w[7:0];
               default: ;
            endcase
         end
      end
   end

   // Both LEDs share the brightness
   assign lit    = pwm_cnt < duty;
   assign o_rgb0 = lit ? led0 : '0;
   assign o_rgb1 = lit ? led1 : '0;

   always_comb begin
      case (ofs)
         RGB_LED0: rdata = bus_word_t'(led0);
         RGB_LED1: rdata = bus_word_t'(led1);
         RGB_DUTY: rdata = bus_word_t'(duty);
         default:  rdata = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      bus.dat_r <= rdata;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.cyc & bus.stb & ~bus.ack;
      end
   end

endmodule

`default_nettype wire

//--- source/wolf_periph.sv
`default_nettype none

module wolf_periph
   import wolf_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst,
   // Processor load/store master
   input  logic       i_cpu_cyc,
   input  logic       i_cpu_stb,
   input  logic       i_cpu_we,
   input  bus_addr_t  i_cpu_adr,
   input  bus_word_t  i_cpu_dat,
   input  bus_sel_t   i_cpu_sel,
   output bus_word_t  o_cpu_rdt,
   output logic       o_cpu_ack,
   output logic       o_cpu_err,
   // Debug system-bus master
   input  logic       i_dbg_cyc,
   input  logic       i_dbg_stb,
   input  logic       i_dbg_we,
   input  bus_addr_t  i_dbg_adr,
   input  bus_word_t  i_dbg_dat,
   input  bus_sel_t   i_dbg_sel,
   output bus_word_t  o_dbg_rdt,
   output logic       o_dbg_ack,
   output logic       o_dbg_err,
   // Peripheral pins
   output logic       o_timer_irq,
   input  bus_word_t  i_gpio,
   output bus_word_t  o_gpio,
   output bus_word_t  o_gpio_oe,
   output rgb_color_t o_rgb0,
   output rgb_color_t o_rgb1
);

   wb_if cpu_bus ();
   wb_if dbg_bus ();
   wb_if main_bus ();
   wb_if ram_bus ();
   wb_if sys_bus ();
   wb_if gpio_bus ();
   wb_if rgb_bus ();

   // ********************
   // Master ports
   assign cpu_bus.cyc   = i_cpu_cyc;
   assign cpu_bus.stb   = i_cpu_stb;
   assign cpu_bus.we    = i_cpu_we;
   assign cpu_bus.adr   = i_cpu_adr;
   assign cpu_bus.dat_w = i_cpu_dat;
   assign cpu_bus.sel   = i_cpu_sel;
   assign o_cpu_rdt     = cpu_bus.dat_r;
   assign o_cpu_ack     = cpu_bus.ack;
   assign o_cpu_err     = cpu_bus.err;

   assign dbg_bus.cyc   = i_dbg_cyc;
   assign dbg_bus.stb   = i_dbg_stb;
   assign dbg_bus.we    = i_dbg_we;
   assign dbg_bus.adr   = i_dbg_adr;
   assign dbg_bus.dat_w = i_dbg_dat;
   assign dbg_bus.sel   = i_dbg_sel;
   assign o_dbg_rdt     = dbg_bus.dat_r;
   assign o_dbg_ack     = dbg_bus.ack;
   assign o_dbg_err     = dbg_bus.err;

   // ********************
   // Interconnect
   wb_arbiter wb_arbiter_inst (
      .clk   (clk),
      .i_rst (i_rst),
      .cpu   (cpu_bus.decoder),
      .dbg   (dbg_bus.decoder),
      .bus   (main_bus.initiator)
   );

   wb_decoder wb_decoder_inst (
      .clk   (clk),
      .i_rst (i_rst),
      .bus   (main_bus.decoder),
      .ram   (ram_bus.initiator),
      .sys   (sys_bus.initiator),
      .gpio  (gpio_bus.initiator),
      .rgb   (rgb_bus.initiator)
   );

   // ********************
   // Targets
   boot_ram boot_ram_inst (
      .clk   (clk),
      .i_rst (i_rst),
      .bus   (ram_bus.target)
   );

   sys_timer sys_timer_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .bus         (sys_bus.target),
      .o_timer_irq (o_timer_irq)
   );

   gpio_port gpio_port_inst (
      .clk       (clk),
      .i_rst     (i_rst),
      .bus       (gpio_bus.target),
      .i_gpio    (i_gpio),
      .o_gpio    (o_gpio),
      .o_gpio_oe (o_gpio_oe)
   );

   rgb_led rgb_led_inst (
      .clk    (clk),
      .i_rst  (i_rst),
      .bus    (rgb_bus.target),
      .o_rgb0 (o_rgb0),
      .o_rgb1 (o_rgb1)
   );

endmodule

`default_nettype wire

//--- bench/wolf_periph_tb.sv
`default_nettype none

module wolf_periph_tb
   import wolf_pkg::*;
();

   // One bus transfer with its expected reply
   typedef struct {
      string     name;
      logic      use_dbg;
      logic      we;
      bus_addr_t adr;
      bus_word_t dat;
      bus_sel_t  sel;
      bus_word_t exp_rdata;
      logic      exp_err;
   } bus_entry_t;

   logic       clk;
   logic       i_rst;
   logic       i_cpu_cyc;
   logic       i_cpu_stb;
   logic       i_cpu_we;
   bus_addr_t  i_cpu_adr;
   bus_word_t  i_cpu_dat;
   bus_sel_t   i_cpu_sel;
   bus_word_t  o_cpu_rdt;
   logic       o_cpu_ack;
   logic       o_cpu_err;
   logic       i_dbg_cyc;
   logic       i_dbg_stb;
   logic       i_dbg_we;
   bus_addr_t  i_dbg_adr;
   bus_word_t  i_dbg_dat;
   bus_sel_t   i_dbg_sel;
   bus_word_t  o_dbg_rdt;
   logic       o_dbg_ack;
   logic       o_dbg_err;
   logic       o_timer_irq;
   bus_word_t  i_gpio;
   bus_word_t  o_gpio;
   bus_word_t  o_gpio_oe;
   rgb_color_t o_rgb0;
   rgb_color_t o_rgb1;

   bus_entry_t stim_q[$];
   bus_word_t  ram_shadow [RAM_WORDS];
   bus_word_t  gpio_out_exp;
   bus_word_t  gpio_oe_exp;
   bus_word_t  rng_state = 32'h0ab573c9;

   wolf_periph wolf_periph_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_cpu_cyc   (i_cpu_cyc),
      .i_cpu_stb   (i_cpu_stb),
      .i_cpu_we    (i_cpu_we),
      .i_cpu_adr   (i_cpu_adr),
      .i_cpu_dat   (i_cpu_dat),
      .i_cpu_sel   (i_cpu_sel),
      .o_cpu_rdt   (o_cpu_rdt),
      .o_cpu_ack   (o_cpu_ack),
      .o_cpu_err   (o_cpu_err),
      .i_dbg_cyc   (i_dbg_cyc),
      .i_dbg_stb   (i_dbg_stb),
      .i_dbg_we    (i_dbg_we),
      .i_dbg_adr   (i_dbg_adr),
      .i_dbg_dat   (i_dbg_dat),
      .i_dbg_sel   (i_dbg_sel),
      .o_dbg_rdt   (o_dbg_rdt),
      .o_dbg_ack   (o_dbg_ack),
      .o_dbg_err   (o_dbg_err),
      .o_timer_irq (o_timer_irq),
      .i_gpio      (i_gpio),
      .o_gpio      (o_gpio),
      .o_gpio_oe   (o_gpio_oe),
      .o_rgb0      (o_rgb0),
      .o_rgb1      (o_rgb1)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ********************
   // Random numbers and address helpers
   function automatic bus_word_t xorshift32(bus_word_t x);
      bus_word_t y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic bus_word_t next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic bus_addr_t reg_addr(logic [3:0] region, logic [REG_OFS_W-1:0] ofs);
      return {region, 8'h00, ofs};
   endfunction

   // Bits 11:10 are don't-care inside the RAM region
   function automatic bus_addr_t ram_addr(logic [1:0] alias_bits, logic [7:0] idx);
      return {REGION_RAM, alias_bits, idx, 2'b00};
   endfunction

   function automatic bus_word_t lane_mask(bus_sel_t sel);
      bus_word_t mask;
      mask = '0;
      for (int b = 0; b < BUS_SEL_W; b++) begin
         if (sel[b]) begin
            mask[8*b +: 8] = 8'hff;
         end
      end
      return mask;
   endfunction

   // ********************
   // Checks
   task automatic fail_run(input string what);
      $display("%s", what);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected 0x%h, actual 0x%h", name, exp, act));
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_color(input string name, input rgb_color_t exp, input rgb_color_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input pwm_t exp, input pwm_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
      end
   endtask

   // ********************
   // Bus master tasks
   task automatic drive_master(input logic use_dbg, input logic active, input logic we,
                               input bus_addr_t adr, input bus_word_t dat, input bus_sel_t sel);
      if (use_dbg) begin
         i_dbg_cyc <= active;
         i_dbg_stb <= active;
         i_dbg_we  <= we;
         i_dbg_adr <= adr;
         i_dbg_dat <= dat;
         i_dbg_sel <= sel;
      end else begin
         i_cpu_cyc <= active;
         i_cpu_stb <= active;
         i_cpu_we  <= we;
         i_cpu_adr <= adr;
         i_cpu_dat <= dat;
         i_cpu_sel <= sel;
      end
   endtask

   // Request held until ack or err and dropped on the next edge
   task automatic bus_access(input logic use_dbg, input logic we, input bus_addr_t adr,
                             input bus_word_t dat, input bus_sel_t sel,
                             output bus_word_t rdata, output logic ack, output logic err);
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      @(posedge clk);
      drive_master(use_dbg, 1'b1, we, adr, dat, sel);
      while (!seen) begin
         @(negedge clk);
         ack    = use_dbg ? o_dbg_ack : o_cpu_ack;
         err    = use_dbg ? o_dbg_err : o_cpu_err;
         rdata  = use_dbg ? o_dbg_rdt : o_cpu_rdt;
         seen   = (ack === 1'b1) || (err === 1'b1);
         waited = waited + 1;
         if (!seen && waited >= 32) begin
            fail_run($sformatf("bus access to 0x%h got neither ack nor err in 32 cycles", adr));
         end
      end
      @(posedge clk);
      drive_master(use_dbg, 1'b0, we, adr, dat, sel);
   endtask

   task automatic reg_write(input string name, input bus_addr_t adr, input bus_word_t dat);
      bus_word_t rdata;
      logic      ack;
      logic      err;
      bus_access(1'b0, 1'b1, adr, dat, 4'hf, rdata, ack, err);
      check_err({name, " ack"}, 1'b1, ack);
      check_err({name, " err"}, 1'b0, err);
   endtask

   // ********************
   // Stimulus table
   function automatic void add_entry(string name, logic use_dbg, logic we, bus_addr_t adr,
                                     bus_word_t dat, bus_sel_t sel, bus_word_t exp_rdata,
                                     logic exp_err);
      bus_entry_t e;
      e.name      = name;
      e.use_dbg   = use_dbg;
      e.we        = we;
      e.adr       = adr;
      e.dat       = dat;
      e.sel       = sel;
      e.exp_rdata = exp_rdata;
      e.exp_err   = exp_err;
      stim_q.push_back(e);
   endfunction

   task automatic build_table();
      bus_word_t  rnd;
      bus_word_t  data;
      logic [7:0] idx;
      rgb_color_t led_exp;
      for (int i = 0; i < 16; i++) begin
         idx = 8'(i * 13 + 5);
         rnd = next_random();
         ram_shadow[idx] = next_random();
         add_entry($sformatf("ram full write %0d", i), i[0], 1'b1, ram_addr(rnd[1:0], idx),
                   ram_shadow[idx], 4'hf, '0, 1'b0);
      end
      // Only the selected byte lanes change
      for (int i = 0; i < 16; i++) begin
         idx  = 8'(i * 13 + 5);
         rnd  = next_random();
         data = next_random();
         ram_shadow[idx] = (ram_shadow[idx] & ~lane_mask(rnd[7:4])) | (data & lane_mask(rnd[7:4]));
         add_entry($sformatf("ram partial write %0d sel %h", i, rnd[7:4]), rnd[8], 1'b1,
                   ram_addr(rnd[1:0], idx), data, rnd[7:4], '0, 1'b0);
      end
      for (int i = 0; i < 16; i++) begin
         idx = 8'(i * 13 + 5);
         rnd = next_random();
         add_entry($sformatf("ram read %0d", i), rnd[8], 1'b0, ram_addr(rnd[1:0], idx),
                   '0, 4'hf, ram_shadow[idx], 1'b0);
      end
      // Regions 4 to 15 are holes
      for (int r = 4; r < 16; r++) begin
         rnd = next_random();
         add_entry($sformatf("hole read region %0d", r), rnd[12], 1'b0, {4'(r), rnd[11:0]},
                   '0, 4'hf, '0, 1'b1);
         add_entry($sformatf("hole write region %0d", r), rnd[13], 1'b1, {4'(r), rnd[27:16]},
                   rnd, 4'hf, '0, 1'b1);
      end
      add_entry("sys ctrl after reset", 1'b0, 1'b0, reg_addr(REGION_SYS, SYS_CTRL),
                '0, 4'hf, '0, 1'b0);
      add_entry("sys mtimecmp after reset", 1'b1, 1'b0, reg_addr(REGION_SYS, SYS_MTIMECMP),
                '0, 4'hf, '1, 1'b0);
      add_entry("sys undefined offset", 1'b1, 1'b0, reg_addr(REGION_SYS, 4'hc),
                '0, 4'hf, '0, 1'b0);
      gpio_out_exp = next_random();
      add_entry("gpio out write", 1'b0, 1'b1, reg_addr(REGION_GPIO, GPIO_OUT),
                gpio_out_exp, 4'hf, '0, 1'b0);
      add_entry("gpio out read", 1'b1, 1'b0, reg_addr(REGION_GPIO, GPIO_OUT),
                '0, 4'hf, gpio_out_exp, 1'b0);
      // Register writes take the whole word whatever sel says
      gpio_oe_exp = next_random();
      add_entry("gpio oe write", 1'b1, 1'b1, reg_addr(REGION_GPIO, GPIO_OE),
                gpio_oe_exp, 4'h1, '0, 1'b0);
      add_entry("gpio oe read", 1'b0, 1'b0, reg_addr(REGION_GPIO, GPIO_OE),
                '0, 4'hf, gpio_oe_exp, 1'b0);
      add_entry("gpio undefined offset", 1'b0, 1'b0, reg_addr(REGION_GPIO, 4'hc),
                '0, 4'hf, '0, 1'b0);
      add_entry("rgb led0 after reset", 1'b1, 1'b0, reg_addr(REGION_RGB, RGB_LED0),
                '0, 4'hf, '0, 1'b0);
      led_exp = rgb_color_t'(next_random() % 7 + 1);
      add_entry("rgb led1 write", 1'b1, 1'b1, reg_addr(REGION_RGB, RGB_LED1),
                bus_word_t'(led_exp), 4'hf, '0, 1'b0);
      add_entry("rgb led1 read", 1'b0, 1'b0, reg_addr(REGION_RGB, RGB_LED1),
                '0, 4'hf, bus_word_t'(led_exp), 1'b0);
      add_entry("rgb undefined offset", 1'b0, 1'b0, reg_addr(REGION_RGB, 4'hc),
                '0, 4'hf, '0, 1'b0);
   endtask

   // ********************
   // Main sequence
   initial begin
      bus_word_t  rdata;
      logic       ack;
      logic       err;
      bus_word_t  rd_a;
      bus_word_t  rd_b;
      logic       ack_a;
      logic       ack_b;
      logic       err_a;
      logic       err_b;
      bus_word_t  dat_a;
      bus_word_t  dat_b;
      bus_word_t  gpio_in_val;
      int         waited;
      int         lit0;
      int         lit1;
      rgb_color_t color0;
      rgb_color_t color1;
      pwm_t       duty_list [3];

      duty_list = '{8'd0, 8'd128, 8'd255};
      i_rst  <= 1'b1;
      i_gpio <= '0;
      drive_master(1'b0, 1'b0, 1'b0, '0, '0, '0);
      drive_master(1'b1, 1'b0, 1'b0, '0, '0, '0);
      repeat (3) @(posedge clk);
      i_rst <= 1'b0;

      @(negedge clk);
      check_err("cpu ack after reset", 1'b0, o_cpu_ack);
      check_err("cpu err after reset", 1'b0, o_cpu_err);
      check_err("dbg ack after reset", 1'b0, o_dbg_ack);
      check_err("dbg err after reset", 1'b0, o_dbg_err);
      check_err("timer irq after reset", 1'b0, o_timer_irq);
      check_word("gpio oe after reset", '0, o_gpio_oe);
      check_color("led0 after reset", '0, o_rgb0);
      check_color("led1 after reset", '0, o_rgb1);

      build_table();
      foreach (stim_q[k]) begin
         bus_access(stim_q[k].use_dbg, stim_q[k].we, stim_q[k].adr, stim_q[k].dat,
                    stim_q[k].sel, rdata, ack, err);
         check_err({stim_q[k].name, " err"}, stim_q[k].exp_err, err);
         check_err({stim_q[k].name, " ack"}, !stim_q[k].exp_err, ack);
         if (!stim_q[k].we) begin
            check_word(stim_q[k].name, stim_q[k].exp_rdata, rdata);
         end
      end

      // GPIO pins
      @(negedge clk);
      check_word("gpio out pins", gpio_out_exp, o_gpio);
      check_word("gpio oe pins", gpio_oe_exp, o_gpio_oe);
      gpio_in_val = next_random();
      @(posedge clk);
      i_gpio <= gpio_in_val;
      repeat (4) @(posedge clk);
      bus_access(1'b0, 1'b0, reg_addr(REGION_GPIO, GPIO_IN), '0, 4'hf, rdata, ack, err);
      check_word("gpio in read", gpio_in_val, rdata);

      // ********************
      // Timer interrupt
      reg_write("mtime clear", reg_addr(REGION_SYS, SYS_MTIME), '0);
      reg_write("mtimecmp 100", reg_addr(REGION_SYS, SYS_MTIMECMP), 32'd100);
      repeat (150) begin
         @(negedge clk);
         check_err("timer irq while disabled", 1'b0, o_timer_irq);
      end
      reg_write("mtime restart", reg_addr(REGION_SYS, SYS_MTIME), '0);
      reg_write("timer enable", reg_addr(REGION_SYS, SYS_CTRL), 32'd1);
      @(negedge clk);
      waited = 0;
      while (o_timer_irq !== 1'b1) begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > 200) begin
            fail_run("timer interrupt did not rise within 200 cycles");
         end
      end
      reg_write("mtimecmp max", reg_addr(REGION_SYS, SYS_MTIMECMP), '1);
      @(negedge clk);
      waited = 0;
      while (o_timer_irq !== 1'b0) begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > 8) begin
            fail_run("timer interrupt stayed high after mtimecmp was set to all ones");
         end
      end

      // ********************
      // RGB brightness over one full PWM period
      color0 = rgb_color_t'(next_random() % 7 + 1);
      color1 = rgb_color_t'(next_random() % 7 + 1);
      reg_write("rgb led0 colour", reg_addr(REGION_RGB, RGB_LED0), bus_word_t'(color0));
      reg_write("rgb led1 colour", reg_addr(REGION_RGB, RGB_LED1), bus_word_t'(color1));
      foreach (duty_list[d]) begin
         reg_write($sformatf("rgb duty %0d", duty_list[d]), reg_addr(REGION_RGB, RGB_DUTY),
                   bus_word_t'(duty_list[d]));
         lit0 = 0;
         lit1 = 0;
         repeat (256) begin
            @(negedge clk);
            if (o_rgb0 !== '0) begin
               lit0 = lit0 + 1;
               check_color("led0 lit colour", color0, o_rgb0);
            end
            if (o_rgb1 !== '0) begin
               lit1 = lit1 + 1;
               check_color("led1 lit colour", color1, o_rgb1);
            end
         end
         if (lit0 > 255 || lit1 > 255) begin
            fail_run($sformatf("an LED stayed lit for all 256 cycles at duty %0d", duty_list[d]));
         end
         check_count($sformatf("led0 lit cycles duty %0d", duty_list[d]), duty_list[d],
                     pwm_t'(lit0));
         check_count($sformatf("led1 lit cycles duty %0d", duty_list[d]), duty_list[d],
                     pwm_t'(lit1));
      end

      // ********************
      // Both masters at once
      dat_a = next_random();
      dat_b = next_random();
      fork
         bus_access(1'b0, 1'b1, ram_addr(2'd1, 8'd250), dat_a, 4'hf, rd_a, ack_a, err_a);
         bus_access(1'b1, 1'b1, ram_addr(2'd2, 8'd251), dat_b, 4'hf, rd_b, ack_b, err_b);
      join
      check_err("contended cpu write ack", 1'b1, ack_a);
      check_err("contended dbg write ack", 1'b1, ack_b);
      check_err("contended cpu write err", 1'b0, err_a);
      check_err("contended dbg write err", 1'b0, err_b);
      fork
         bus_access(1'b0, 1'b0, ram_addr(2'd3, 8'd251), '0, 4'hf, rd_a, ack_a, err_a);
         bus_access(1'b1, 1'b0, ram_addr(2'd0, 8'd250), '0, 4'hf, rd_b, ack_b, err_b);
      join
      check_err("contended cpu read ack", 1'b1, ack_a);
      check_err("contended dbg read ack", 1'b1, ack_b);
      check_err("contended cpu read err", 1'b0, err_a);
      check_err("contended dbg read err", 1'b0, err_b);
      check_word("contended cpu read", dat_b, rd_a);
      check_word("contended dbg read", dat_a, rd_b);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- wolf_periph.f
source/wolf_pkg.sv
source/wb_if.sv
source/wb_arbiter.sv
source/wb_decoder.sv
source/boot_ram.sv
source/sys_timer.sv
source/gpio_port.sv
source/rgb_led.sv
source/wolf_periph.sv
bench/wolf_periph_tb.sv

//--- Bender.yml
package:
  name: wolf_periph

sources:
  - source/wolf_pkg.sv
  - source/wb_if.sv
  - source/wb_arbiter.sv
  - source/wb_decoder.sv
  - source/boot_ram.sv
  - source/sys_timer.sv
  - source/gpio_port.sv
  - source/rgb_led.sv
  - source/wolf_periph.sv
  - target: test
    files:
      - bench/wolf_periph_tb.sv
